/* dv/tcdm_amo_adapter_tb.sv */
// Reads dv/tcdm_amo_cases.txt by a path relative to the project root, so it must run from there
`timescale 1ns/10ps

module tcdm_amo_adapter_tb;

  import tcdm_bus_pkg::*;
  import tcdm_amo_pkg::*;

  // Watchdog budget per case line in clock cycles
  localparam int cycle_budget = 40;

  logic    clk_i;
  logic    rst_ni;
  logic    in_valid_i;
  logic    in_ready_o;
  addr_t   in_addr_i;
  amo_op_e in_amo_i;
  logic    in_write_i;
  data_t   in_wdata_i;
  be_t     in_be_i;
  meta_t   in_meta_i;
  logic    in_valid_o;
  logic    in_ready_i;
  data_t   in_rdata_o;
  meta_t   in_meta_o;
  logic    out_req_o;
  addr_t   out_addr_o;
  logic    out_write_o;
  data_t   out_wdata_o;
  be_t     out_be_o;
  data_t   out_rdata_i;

  // Request fields with one entry per case line
  logic [3:0] req_op_q[$];
  logic       req_wr_q[$];
  addr_t      req_addr_q[$];
  data_t      req_wdata_q[$];
  be_t        req_be_q[$];
  meta_t      req_meta_q[$];
  // Expected responses in request order
  data_t      exp_data_q[$];
  meta_t      exp_meta_q[$];
  string      exp_name_q[$];

  int          n_cases;
  logic        cases_loaded;
  logic [31:0] lfsr_q;

  // ------------------------------
  // DUT and memory
  // ------------------------------

  tcdm_amo_adapter UUT (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .in_addr_i  (in_addr_i),
    .in_amo_i   (in_amo_i),
    .in_write_i (in_write_i),
    .in_wdata_i (in_wdata_i),
    .in_be_i    (in_be_i),
    .in_meta_i  (in_meta_i),
    .in_valid_o (in_valid_o),
    .in_ready_i (in_ready_i),
    .in_rdata_o (in_rdata_o),
    .in_meta_o  (in_meta_o),
    .out_req_o  (out_req_o),
    .out_addr_o (out_addr_o),
    .out_write_o(out_write_o),
    .out_wdata_o(out_wdata_o),
    .out_be_o   (out_be_o),
    .out_rdata_i(out_rdata_i)
  );

  tcdm_sram_model i_sram (
    .clk_i  (clk_i),
    .req_i  (out_req_o),
    .addr_i (out_addr_o),
    .write_i(out_write_o),
    .wdata_i(out_wdata_o),
    .be_i   (out_be_o),
    .rdata_o(out_rdata_i)
  );

  // 8 ns period
  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    lfsr_next = {s[30:0], fb};
  endfunction

  // ------------------------------
  // Case reader
  // ------------------------------

  task automatic load_cases();
    int         fd;
    int         rc;
    string      line;
    logic [3:0] f_op;
    logic       f_wr;
    addr_t      f_addr;
    data_t      f_wdata;
    be_t        f_be;
    meta_t      f_meta;
    data_t      f_exp;
    string      f_name;
    fd = $fopen("dv/tcdm_amo_cases.txt", "r");
    assert (fd != 0) else begin
      $display("Could not open the case file dv/tcdm_amo_cases.txt");
      $display("SIMULATION FAILED");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      rc = $fgets(line, fd);
      // Comment and blank lines never give eight fields
      if (rc != 0) begin
        rc = $sscanf(line, "%h %h %h %h %h %h %h %s",
                     f_op, f_wr, f_addr, f_wdata, f_be, f_meta, f_exp, f_name);
        if (rc == 8) begin
          req_op_q.push_back(f_op);
          req_wr_q.push_back(f_wr);
          req_addr_q.push_back(f_addr);
          req_wdata_q.push_back(f_wdata);
          req_be_q.push_back(f_be);
          req_meta_q.push_back(f_meta);
          // Loads and AMOs answer, stores stay silent
          if (f_op != 4'h0 || !f_wr) begin
            exp_data_q.push_back(f_exp);
            exp_meta_q.push_back(f_meta);
            exp_name_q.push_back(f_name);
          end
        end
      end
    end
    $fclose(fd);
    n_cases = req_op_q.size();
    assert (n_cases > 0) else begin
      $display("The case file holds no usable request line");
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  // ------------------------------
  // Driver and checker
  // ------------------------------

  task automatic drive_requests();
    for (int i = 0; i < n_cases; i++) begin
      @(negedge clk_i);
      in_valid_i = 1'b1;
      in_amo_i   = amo_op_e'(req_op_q[i]);
      in_write_i = req_wr_q[i];
      in_addr_i  = req_addr_q[i];
      in_wdata_i = req_wdata_q[i];
      in_be_i    = req_be_q[i];
      in_meta_i  = req_meta_q[i];
      // Ready settles after the checker has set in_ready_i
      #1;
      while (!in_ready_o) begin
        @(negedge clk_i);
        #1;
      end
    end
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  task automatic check_responses();
    while (exp_data_q.size() != 0) begin
      @(negedge clk_i);
      lfsr_q     = lfsr_next(lfsr_q);
      in_ready_i = lfsr_q[0];
      #1;
      // Handshake lands on the coming rising edge
      if (in_valid_o && in_ready_i) begin
        assert (in_meta_o == exp_meta_q[0]) else begin
          $display("ERROR %s: meta expected %h, actual %h",
                   exp_name_q[0], exp_meta_q[0], in_meta_o);
          $display("SIMULATION FAILED");
          $fatal(1);
        end
        assert (in_rdata_o == exp_data_q[0]) else begin
          $display("ERROR %s: rdata expected %h, actual %h",
                   exp_name_q[0], exp_data_q[0], in_rdata_o);
          $display("SIMULATION FAILED");
          $fatal(1);
        end
        void'(exp_data_q.pop_front());
        void'(exp_meta_q.pop_front());
        void'(exp_name_q.pop_front());
      end
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial begin
    rst_ni       = 1'b0;
    in_valid_i   = 1'b0;
    in_addr_i    = '0;
    in_amo_i     = amo_none;
    in_write_i   = 1'b0;
    in_wdata_i   = '0;
    in_be_i      = '0;
    in_meta_i    = '0;
    in_ready_i   = 1'b0;
    lfsr_q       = 32'd90162;
    cases_loaded = 1'b0;
    load_cases();
    cases_loaded = 1'b1;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    // Quiet bus before the first request
    repeat (4) begin
      @(negedge clk_i);
      #1;
      assert (!in_valid_o && !out_req_o) else begin
        $display("ERROR idle_after_reset: valid/req expected 0/0, actual %b/%b",
                 in_valid_o, out_req_o);
        $display("SIMULATION FAILED");
        $fatal(1);
      end
    end
    fork
      drive_requests();
      check_responses();
    join
    // Nothing may follow the last expected response
    @(negedge clk_i);
    in_ready_i = 1'b1;
    repeat (10) begin
      #1;
      assert (!in_valid_o) else begin
        $display("An extra response with meta %h came after the last expected one", in_meta_o);
        $display("SIMULATION FAILED");
        $fatal(1);
      end
      @(negedge clk_i);
    end
    $display("SIMULATION PASSED");
    $finish;
  end

  // Watchdog
  initial begin
    wait (cases_loaded == 1'b1);
    repeat (n_cases * cycle_budget) @(posedge clk_i);
    $display("Timeout, responses still missing after %0d cycles", n_cases * cycle_budget);
    $display("SIMULATION FAILED");
    $fatal(1);
  end

endmodule

/* dv/tcdm_amo_cases.txt */
# op wr addr wdata be meta exp_rdata name, all hex except the name
# op 0 is a plain access, stores carry 0 as exp_rdata and get no response
0 1 00000000 11223344 f 00 00000000 st_full
0 1 00000000 aabbccdd 5 00 00000000 st_partial
0 0 00000000 00000000 f 01 11bb33dd ld_merged
0 0 00000040 00000000 f 02 d00d0010 ld_fill
0 1 00000080 00000005 f 00 00000000 st_amo_base
1 0 00000080 80000003 f 10 00000005 amo_swap
2 0 00000080 00000010 f 11 80000003 amo_add
0 0 00000080 00000000 f 12 80000013 ld_after_add
3 0 00000080 0000ff0f f 13 80000013 amo_and
4 0 00000080 12340000 f 14 00000003 amo_or
5 0 00000080 ffff00ff f 15 12340003 amo_xor
0 0 00000080 00000000 f 16 edcb00fc ld_after_xor
6 0 00000080 00000007 f 17 edcb00fc amo_max
7 0 00000080 fffffff0 f 18 00000007 amo_maxu
8 0 00000080 ffffff00 f 19 fffffff0 amo_min
9 0 00000080 00000020 f 1a ffffff00 amo_minu
0 0 00000080 00000000 f 1b 00000020 ld_after_minu
6 0 00000080 80000000 f 1c 00000020 amo_max_keep
7 0 00000080 00000010 f 1d 00000020 amo_maxu_keep
8 0 00000080 7fffffff f 1e 00000020 amo_min_keep
9 0 00000080 ffffffff f 1f 00000020 amo_minu_keep
2 0 00000080 ffffffe0 f 20 00000020 amo_add_wrap
0 0 00000080 00000000 f 21 00000000 ld_after_wrap
0 0 00000044 00000000 f 22 d00d0011 ld_seq_a
0 0 00000048 00000000 f 23 d00d0012 ld_seq_b

/* dv/tcdm_sram_model.sv */
// Behavioral SRAM, word index from the address bits above the byte offset and upper bits ignored
`timescale 1ns/10ps

`include "tcdm_amo_macros.svh"

module tcdm_sram_model (
  input  logic                clk_i,
  input  logic                req_i,
  input  tcdm_bus_pkg::addr_t addr_i,
  input  logic                write_i,
  input  tcdm_bus_pkg::data_t wdata_i,
  input  tcdm_bus_pkg::be_t   be_i,
  output tcdm_bus_pkg::data_t rdata_o
);

  import tcdm_bus_pkg::*;

  localparam int depth = 1 << `TCDM_SRAM_IDX_W;

  data_t                       mem [depth];
  logic [`TCDM_SRAM_IDX_W-1:0] idx;

  // Word address, byte offset dropped
  assign idx = addr_i[`TCDM_SRAM_IDX_W+1:2];

  // Fill tagged with the word index
  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i[`TCDM_SRAM_IDX_W-1:0]] <= {16'hd00d, 16'(i)};
    end
  end

  // One-cycle read latency, read data held until the next read
  always @(posedge clk_i) begin
    if (req_i) begin
      if (write_i) begin
        for (int b = 0; b < `TCDM_DATA_W/8; b++) begin
          if (be_i[b]) begin
            mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem[idx];
      end
    end
  end

endmodule

/* hw/tcdm_amo_adapter.sv */
// Needs exclusive access to a single-port SRAM with one-cycle read latency and no stalls
`timescale 1ns/10ps

module tcdm_amo_adapter (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Front request
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  tcdm_bus_pkg::addr_t   in_addr_i,
  input  tcdm_amo_pkg::amo_op_e in_amo_i,
  input  logic                  in_write_i,
  input  tcdm_bus_pkg::data_t   in_wdata_i,
  input  tcdm_bus_pkg::be_t     in_be_i,
  input  tcdm_bus_pkg::meta_t   in_meta_i,
  // Front response
  output logic                  in_valid_o,
  input  logic                  in_ready_i,
  output tcdm_bus_pkg::data_t   in_rdata_o,
  output tcdm_bus_pkg::meta_t   in_meta_o,
  // SRAM port
  output logic                  out_req_o,
  output tcdm_bus_pkg::addr_t   out_addr_o,
  output logic                  out_write_o,
  output tcdm_bus_pkg::data_t   out_wdata_o,
  output tcdm_bus_pkg::be_t     out_be_o,
  input  tcdm_bus_pkg::data_t   out_rdata_i
);

  import tcdm_bus_pkg::*;
  import tcdm_amo_pkg::*;

  logic    resp_stall;
  logic    meta_push;
  logic    rdata_push;
  amo_op_e amo_op;
  data_t   amo_operand;
  data_t   amo_result;

  tcdm_req_ctrl i_req_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .in_addr_i    (in_addr_i),
    .in_amo_i     (in_amo_i),
    .in_write_i   (in_write_i),
    .in_wdata_i   (in_wdata_i),
    .in_be_i      (in_be_i),
    .resp_stall_i (resp_stall),
    .meta_push_o  (meta_push),
    .rdata_push_o (rdata_push),
    .amo_op_o     (amo_op),
    .amo_operand_o(amo_operand),
    .amo_result_i (amo_result),
    .out_req_o    (out_req_o),
    .out_addr_o   (out_addr_o),
    .out_write_o  (out_write_o),
    .out_wdata_o  (out_wdata_o),
    .out_be_o     (out_be_o)
  );

  // Old word comes straight from the SRAM in the write cycle
  tcdm_amo_alu i_amo_alu (
    .amo_op_i (amo_op),
    .old_i    (out_rdata_i),
    .operand_i(amo_operand),
    .result_o (amo_result)
  );

  tcdm_resp_buffer i_resp_buffer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .meta_push_i (meta_push),
    .meta_i      (in_meta_i),
    .rdata_push_i(rdata_push),
    .rdata_i     (out_rdata_i),
    .in_valid_o  (in_valid_o),
    .in_ready_i  (in_ready_i),
    .in_rdata_o  (in_rdata_o),
    .in_meta_o   (in_meta_o),
    .resp_stall_o(resp_stall)
  );

endmodule

/* hw/tcdm_amo_alu.sv */
// Purely combinational and sized for the 32-bit data word of the macro header
`timescale 1ns/10ps

`include "tcdm_amo_macros.svh"

module tcdm_amo_alu (
  input  tcdm_amo_pkg::amo_op_e amo_op_i,
  input  tcdm_bus_pkg::data_t   old_i,
  input  tcdm_bus_pkg::data_t   operand_i,
  output tcdm_bus_pkg::data_t   result_o
);

  import tcdm_amo_pkg::*;

  // Two guard bits so a signed or unsigned difference never overflows
  localparam int unsigned sum_w = `TCDM_DATA_W + 2;

  logic [sum_w-1:0] adder_a;
  logic [sum_w-1:0] adder_b;
  logic [sum_w-1:0] ext_b;
  logic [sum_w-1:0] adder_sum;
  logic             signed_cmp;
  logic             is_sub;
  logic             is_less;

  assign signed_cmp = (amo_op_i == amo_max) || (amo_op_i == amo_min);
  assign is_sub     = amo_op_i inside {amo_max, amo_maxu, amo_min, amo_minu};

  // Sign extend for signed compares, zero extend otherwise
  assign adder_a = {{2{signed_cmp & old_i[`TCDM_DATA_W-1]}}, old_i};
  assign ext_b   = {{2{signed_cmp & operand_i[`TCDM_DATA_W-1]}}, operand_i};

  // Shared adder, subtract as old + ~operand + 1
  assign adder_b   = is_sub ? ~ext_b : ext_b;
  assign adder_sum = adder_a + adder_b + {{(sum_w-1){1'b0}}, is_sub};
  // Negative difference means old < operand
  assign is_less   = adder_sum[sum_w-1];

  always_comb begin
    case (amo_op_i)
      amo_swap: result_o = operand_i;
      amo_add:  result_o = adder_sum[`TCDM_DATA_W-1:0];
      amo_and:  result_o = old_i & operand_i;
      amo_or:   result_o = old_i | operand_i;
      amo_xor:  result_o = old_i ^ operand_i;
      // Larger value wins
      amo_max,
      amo_maxu: result_o = is_less ? operand_i : old_i;
      // Smaller value wins
      amo_min,
      amo_minu: result_o = is_less ? old_i : operand_i;
      default:  result_o = '0;
    endcase
  end

endmodule

/* hw/tcdm_amo_pkg.sv */
// AMO opcode encoding matches the requester side and LR/SC and queue codes are not decoded
package tcdm_amo_pkg;

  // ------------------------------
  // Atomic opcodes
  // ------------------------------

  // Zero means a plain load or store
  typedef enum logic [3:0] {
    amo_none = 4'h0,
    amo_swap = 4'h1,
    amo_add  = 4'h2,
    amo_and  = 4'h3,
    amo_or   = 4'h4,
    amo_xor  = 4'h5,
    amo_max  = 4'h6,
    amo_maxu = 4'h7,
    amo_min  = 4'h8,
    amo_minu = 4'h9
  } amo_op_e;

  // ------------------------------
  // Request controller states
  // ------------------------------

  // Idle passes requests through
  // AMO write owns the SRAM for one cycle
  typedef enum logic {
    st_idle,
    st_amo_write
  } ctrl_state_e;

endpackage

/* hw/tcdm_bus_pkg.sv */
// Bus-side types whose widths follow the macro header and cannot be set per instance
`include "tcdm_amo_macros.svh"

package tcdm_bus_pkg;

  // Byte address of one word
  typedef logic [`TCDM_ADDR_W-1:0] addr_t;

  // Full data word
  typedef logic [`TCDM_DATA_W-1:0] data_t;

  // Byte enables, one per byte lane
  typedef logic [`TCDM_DATA_W/8-1:0] be_t;

  // Requester tag, carried through untouched
  typedef logic [`TCDM_META_W-1:0] meta_t;

endpackage

/* hw/tcdm_req_ctrl.sv */
// Assumes an SRAM that never stalls and answers one cycle after a read strobe
`timescale 1ns/10ps

module tcdm_req_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Front request
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  tcdm_bus_pkg::addr_t   in_addr_i,
  input  tcdm_amo_pkg::amo_op_e in_amo_i,
  input  logic                  in_write_i,
  input  tcdm_bus_pkg::data_t   in_wdata_i,
  input  tcdm_bus_pkg::be_t     in_be_i,
  // Response buffer handshake
  input  logic                  resp_stall_i,
  output logic                  meta_push_o,
  output logic                  rdata_push_o,
  // AMO ALU
  output tcdm_amo_pkg::amo_op_e amo_op_o,
  output tcdm_bus_pkg::data_t   amo_operand_o,
  input  tcdm_bus_pkg::data_t   amo_result_i,
  // SRAM request
  output logic                  out_req_o,
  output tcdm_bus_pkg::addr_t   out_addr_o,
  output logic                  out_write_o,
  output tcdm_bus_pkg::data_t   out_wdata_o,
  output tcdm_bus_pkg::be_t     out_be_o
);

  import tcdm_bus_pkg::*;
  import tcdm_amo_pkg::*;

  ctrl_state_e state_q, state_d;

  // Captured AMO request
  amo_op_e amo_op_q;
  addr_t   addr_q;
  data_t   operand_q;

  logic req_accepted;
  logic is_amo;
  logic read_strobe;
  logic rdata_push_q;

  // ------------------------------
  // Acceptance
  // ------------------------------

  assign is_amo       = (in_amo_i != amo_none);
  // Blocked while a response waits or the AMO write owns the SRAM
  assign in_ready_o   = (state_q == st_idle) && !resp_stall_i;
  assign req_accepted = in_valid_i && in_ready_o;
  // Loads and AMOs return a response, stores do not
  assign meta_push_o  = req_accepted && (is_amo || !in_write_i);

  // ------------------------------
  // SRAM request mux and FSM
  // ------------------------------

  always_comb begin
    state_d     = state_q;
    // Default is a straight feed-through of the front request
    out_req_o   = req_accepted;
    out_addr_o  = in_addr_i;
    out_write_o = in_write_i;
    out_wdata_o = in_wdata_i;
    out_be_o    = in_be_i;

    case (state_q)
      st_idle: begin
        // AMO starts with a read of the old word
        if (is_amo) begin
          out_write_o = 1'b0;
        end
        if (req_accepted && is_amo) begin
          state_d = st_amo_write;
        end
      end
      st_amo_write: begin
        // Write back the ALU result over the whole word
        out_req_o   = 1'b1;
        out_write_o = 1'b1;
        out_addr_o  = addr_q;
        out_wdata_o = amo_result_i;
        out_be_o    = '1;
        state_d     = st_idle;
      end
      default: state_d = st_idle;
    endcase
  end

  // Read data shows up one cycle after this
  assign read_strobe = out_req_o && !out_write_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= st_idle;
      rdata_push_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      rdata_push_q <= read_strobe;
    end
  end

  // Opcode, address and operand held for the write cycle
  always_ff @(posedge clk_i) begin
    if (req_accepted && is_amo) begin
      amo_op_q  <= in_amo_i;
      addr_q    <= in_addr_i;
      operand_q <= in_wdata_i;
    end
  end

  assign rdata_push_o  = rdata_push_q;
  assign amo_op_o      = amo_op_q;
  assign amo_operand_o = operand_q;

endmodule

/* hw/tcdm_resp_buffer.sv */
// Holds at most two tags and one data word and expects data only after its tag was pushed
`timescale 1ns/10ps

module tcdm_resp_buffer (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Metadata capture at request acceptance
  input  logic                meta_push_i,
  input  tcdm_bus_pkg::meta_t meta_i,
  // Read data from the SRAM
  input  logic                rdata_push_i,
  input  tcdm_bus_pkg::data_t rdata_i,
  // Front response
  output logic                in_valid_o,
  input  logic                in_ready_i,
  output tcdm_bus_pkg::data_t in_rdata_o,
  output tcdm_bus_pkg::meta_t in_meta_o,
  // Back-pressure to the request side
  output logic                resp_stall_o
);

  import tcdm_bus_pkg::*;

  // Metadata FIFO
  meta_t      meta_mem [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       meta_valid;

  // Fall-through data register
  data_t data_q;
  logic  data_full_q;
  logic  rdata_valid;

  logic resp_pop;

  // ------------------------------
  // Response handshake
  // ------------------------------

  assign meta_valid   = (count_q != 2'd0);
  // Fresh SRAM data is usable in the cycle it arrives
  assign rdata_valid  = data_full_q || rdata_push_i;
  // Data always comes last, so valid waits on both
  assign in_valid_o   = meta_valid && rdata_valid;
  assign in_meta_o    = meta_mem[rd_ptr_q];
  assign in_rdata_o   = data_full_q ? data_q : rdata_i;
  assign resp_pop     = in_valid_o && in_ready_i;
  assign resp_stall_o = in_valid_o && !in_ready_i;

  // ------------------------------
  // Storage
  // ------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q    <= 1'b0;
      rd_ptr_q    <= 1'b0;
      count_q     <= 2'd0;
      data_full_q <= 1'b0;
    end else begin
      if (meta_push_i) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (resp_pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      case ({meta_push_i, resp_pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
      // Keep the word if nobody took it
      data_full_q <= rdata_valid && !resp_pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (meta_push_i) begin
      meta_mem[wr_ptr_q] <= meta_i;
    end
    // Only captured when the register is free
    if (rdata_push_i && !data_full_q) begin
      data_q <= rdata_i;
    end
  end

endmodule

/* include/tcdm_amo_macros.svh */
// Fixed bus widths for the adapter. Only a 32-bit data word is supported by the AMO ALU
`ifndef TCDM_AMO_MACROS_SVH
`define TCDM_AMO_MACROS_SVH

// ------------------------------
// Bus widths
// ------------------------------

// Byte address width of the front and SRAM ports
`define TCDM_ADDR_W 32

// Data word width, one enable bit per byte
`define TCDM_DATA_W 32

// Opaque requester tag returned with each response
`define TCDM_META_W 8

// ------------------------------
// Memory sizing
// ------------------------------

// Word index width of the SRAM bank behind the adapter
`define TCDM_SRAM_IDX_W 8

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the adapter testbench with Verilator from the project root
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  -f tcdm_amo_adapter.f \
  --top-module tcdm_amo_adapter_tb \
  -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtcdm_amo_adapter_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
exit 0

/* tcdm_amo_adapter.f */
+incdir+include
hw/tcdm_bus_pkg.sv
hw/tcdm_amo_pkg.sv
hw/tcdm_req_ctrl.sv
hw/tcdm_amo_alu.sv
hw/tcdm_resp_buffer.sv
hw/tcdm_amo_adapter.sv
dv/tcdm_sram_model.sv
dv/tcdm_amo_adapter_tb.sv
